/* logic/smc_config.svh */
// SMC strobe generator configuration, field widths and the wait-state count split
`ifndef SMC_CONFIG_SVH
`define SMC_CONFIG_SVH

//----------------------------------------
// Controller state encoding
//----------------------------------------
`define SMC_STATE_WIDTH 5       // One-hot, five states

//----------------------------------------
// Access and timing fields
//----------------------------------------
`define SMC_BE_WIDTH 4          // Byte lanes on the external bus

// Edge-timing store fields and the write-edge counter
`define SMC_EDGE_WIDTH 2

`define SMC_WS_WIDTH 8          // Wait-state store and count

// Low bits of the wait-state value, compared against the edge fields
// The remaining upper bits are the coarse part
`define SMC_WS_FINE_WIDTH 2

`endif

/* logic/smc_pkg.sv */
// SMC strobe generator shared types, controller states and grouped bus fields
`include "smc_config.svh"

package smc_pkg;

   //----------------------------------------
   // Controller state, one-hot
   //----------------------------------------
   typedef enum logic [`SMC_STATE_WIDTH-1:0]
   {
      SMC_IDLE  = 5'b00001,
      SMC_LE    = 5'b00010,   // Leading edge
      SMC_RW    = 5'b00100,   // Read/write strobe active
      SMC_STORE = 5'b01000,
      SMC_FLOAT = 5'b10000    // Bus turnaround
   } smc_state_e;

   //----------------------------------------
   // Access request from the bus side
   //----------------------------------------
   typedef struct packed
   {
      logic                     valid_access;   // Request strobe
      logic                     n_read;         // Low for read
      logic                     cs;
      logic [`SMC_BE_WIDTH-1:0] n_be;           // Active low byte enables
   } smc_access_t;

   // Stored edge timing, loaded by the controller per access
   typedef struct packed
   {
      logic [`SMC_EDGE_WIDTH-1:0] wele_store;   // Write leading edge
      logic [`SMC_EDGE_WIDTH-1:0] wete_store;   // Write trailing edge
      logic [`SMC_EDGE_WIDTH-1:0] oete_store;   // Output enable trailing edge
      logic [`SMC_WS_WIDTH-1:0]   ws_store;
   } smc_timing_store_t;

   // Running counters
   typedef struct packed
   {
      logic [`SMC_EDGE_WIDTH-1:0] wele_count;
      logic [`SMC_WS_WIDTH-1:0]   ws_count;
   } smc_timing_count_t;

   // Direction and chip select held over a cycle or burst
   typedef struct packed
   {
      logic n_r_read;
      logic r_cs;
   } smc_cycle_attr_t;

   // External strobes, all active low
   typedef struct packed
   {
      logic                     n_rd;
      logic                     n_ext_oe;
      logic [`SMC_BE_WIDTH-1:0] n_we;
      logic                     n_wr;
   } smc_ext_strobe_t;

endpackage

/* logic/smc_cycle_latch.sv */
// SMC cycle latch, holds direction and chip select over a burst and flags busy
`timescale 1ns/1ps

module smc_cycle_latch
   import smc_pkg::*;
(
   input  logic            sys_clk,
   input  logic            n_sys_reset,
   input  smc_access_t     access,
   input  logic            smc_done,
   input  logic            mac_done,
   input  smc_state_e      next_state,
   output smc_cycle_attr_t cycle_attr,
   output logic            busy
);

   logic burst_end;   // Last access of the burst done

   assign burst_end = smc_done & mac_done & ~access.valid_access;

   //----------------------------------------
   // Direction and chip select
   //----------------------------------------
   always_ff @(posedge sys_clk or negedge n_sys_reset)
   begin
      if (!n_sys_reset)
      begin
         cycle_attr <= '0;
      end
      else if (access.valid_access)
      begin
         cycle_attr.n_r_read <= access.n_read;   // New access
         cycle_attr.r_cs     <= access.cs;
      end
      else if (burst_end)
      begin
         cycle_attr <= '0;
      end
   end

   // Busy whenever the controller leaves idle
   always_ff @(posedge sys_clk or negedge n_sys_reset)
   begin
      if (!n_sys_reset)
      begin
         busy <= 1'b0;
      end
      else
      begin
         busy <= (next_state != SMC_IDLE);
      end
   end

   //----------------------------------------
   // Checks
   //----------------------------------------
   // Controller heading for idle must not raise busy
   busy_rise_from_active: assert property (
      @(posedge sys_clk) disable iff (!n_sys_reset)
      $rose(busy) |-> ($past(next_state) != SMC_IDLE)
   )
   else
      $error("busy rose while next_state was SMC_IDLE");

endmodule

/* logic/smc_write_strobe.sv */
// SMC write strobe block, registered byte write enables, write strobe and bus output enable
`timescale 1ns/1ps
`include "smc_config.svh"

module smc_write_strobe
   import smc_pkg::*;
(
   input  logic                     sys_clk,
   input  logic                     n_sys_reset,
   input  smc_access_t              access,
   input  logic                     n_r_read,
   input  smc_state_e               next_state,
   output logic [`SMC_BE_WIDTH-1:0] n_we,
   output logic                     n_wr,
   output logic                     n_ext_oe
);

   logic new_write;    // Write requested this cycle
   logic held_write;   // Write continuing from the latched direction
   logic not_store;
   logic write_cond;
   logic oe_cond;

   assign new_write  = access.valid_access & access.n_read;
   assign held_write = ~access.valid_access & n_r_read;
   assign not_store  = (next_state != SMC_STORE);

   assign write_cond = not_store & (new_write | held_write);

   // Drivers released once the controller returns to idle
   assign oe_cond = not_store &
                    (new_write | (held_write & (next_state != SMC_IDLE)));

   //----------------------------------------
   // Write strobes
   //----------------------------------------
   always_ff @(posedge sys_clk or negedge n_sys_reset)
   begin
      if (!n_sys_reset)
      begin
         n_we <= '1;
         n_wr <= 1'b1;
      end
      else if (write_cond)
      begin
         n_we <= access.n_be;   // Per-lane enables
         n_wr <= 1'b0;
      end
      else
      begin
         n_we <= '1;
         n_wr <= 1'b1;
      end
   end

   // External bus drivers
   always_ff @(posedge sys_clk or negedge n_sys_reset)
   begin
      if (!n_sys_reset)
      begin
         n_ext_oe <= 1'b1;
      end
      else
      begin
         n_ext_oe <= ~oe_cond;
      end
   end

   // No byte lane may be enabled without the write strobe
   we_within_wr: assert property (
      @(posedge sys_clk) disable iff (!n_sys_reset)
      n_wr |-> (n_we == '1)
   )
   else
      $error("n_we active while n_wr is high");

endmodule

/* logic/smc_full_cycle.sv */
// SMC full-cycle flag, decides whether the coming write strobe spans a whole clock
`timescale 1ns/1ps
`include "smc_config.svh"

module smc_full_cycle
   import smc_pkg::*;
(
   input  logic              sys_clk,
   input  logic              n_sys_reset,
   input  smc_state_e        cur_state,
   input  smc_state_e        next_state,
   input  logic              valid_access,
   input  logic              smc_done,
   input  smc_timing_store_t store,
   input  smc_timing_count_t count,
   output logic              full
);

   //----------------------------------------
   // Wait-state splits
   //----------------------------------------
   logic [`SMC_WS_FINE_WIDTH-1:0]             cnt_fine;
   logic [`SMC_WS_WIDTH-1:`SMC_WS_FINE_WIDTH] cnt_coarse;
   logic [`SMC_WS_FINE_WIDTH-1:0]             st_fine;
   logic [`SMC_WS_WIDTH-1:`SMC_WS_FINE_WIDTH] st_coarse;

   logic [`SMC_EDGE_WIDTH-1:0] wete_plus;   // Trailing edge one cycle later

   logic wele_short;     // Leading edge counter nearly expired
   logic cnt_late;       // Trailing edge before the end of the wait count
   logic cnt_late_next;
   logic store_late;     // Same test on the stored wait states
   logic long_wait;
   logic full_next;

   assign cnt_fine   = count.ws_count[`SMC_WS_FINE_WIDTH-1:0];
   assign cnt_coarse = count.ws_count[`SMC_WS_WIDTH-1:`SMC_WS_FINE_WIDTH];
   assign st_fine    = store.ws_store[`SMC_WS_FINE_WIDTH-1:0];
   assign st_coarse  = store.ws_store[`SMC_WS_WIDTH-1:`SMC_WS_FINE_WIDTH];

   assign wete_plus = store.wete_store + `SMC_EDGE_WIDTH'(1);

   assign wele_short    = (count.wele_count < `SMC_EDGE_WIDTH'(2));
   assign cnt_late      = (store.wete_store < cnt_fine) | (cnt_coarse != '0);
   assign cnt_late_next = (wete_plus < cnt_fine) | (cnt_coarse != '0);
   assign store_late    = (store.wete_store < st_fine) | (st_coarse != '0);
   assign long_wait     = (count.ws_count > `SMC_WS_WIDTH'(4));

   //----------------------------------------
   // Decision per current state
   //----------------------------------------
   always_comb
   begin
      full_next = 1'b0;
      if (next_state == SMC_RW)
      begin
         case (cur_state)
            SMC_LE:
               full_next = cnt_late & wele_short;
            SMC_STORE:
               full_next = cnt_late & (count.wele_count == '0);   // Stricter edge count
            SMC_RW, SMC_FLOAT:
            begin
               if (valid_access)
                  full_next = 1'b0;   // Fresh access restarts timing
               else if (smc_done)
                  full_next = store_late & (store.wele_store == '0);
               else if (store.wete_store == `SMC_EDGE_WIDTH'(3))
                  full_next = long_wait & wele_short;
               else
                  full_next = cnt_late_next & wele_short;
            end
            default:
               full_next = 1'b0;   // Idle never starts a full write
         endcase
      end
   end

   always_ff @(posedge sys_clk or negedge n_sys_reset)
   begin
      if (!n_sys_reset)
      begin
         full <= 1'b0;
      end
      else
      begin
         full <= full_next;
      end
   end

   // Controller state register must stay one-hot
   cur_state_onehot: assert property (
      @(posedge sys_clk) disable iff (!n_sys_reset)
      $onehot(cur_state)
   )
   else
      $error("cur_state is not one-hot");

endmodule

/* logic/smc_read_strobe.sv */
// SMC read strobe, registered and timed against the output-enable trailing edge
`timescale 1ns/1ps
`include "smc_config.svh"

module smc_read_strobe
   import smc_pkg::*;
(
   input  logic                     sys_clk,
   input  logic                     n_sys_reset,
   input  smc_state_e               cur_state,
   input  smc_state_e               next_state,
   input  smc_access_t              access,
   input  logic                     n_r_read,
   input  smc_timing_store_t        store,
   input  logic [`SMC_WS_WIDTH-1:0] ws_count,
   output logic                     n_rd
);

   logic [`SMC_WS_FINE_WIDTH-1:0]             st_fine;
   logic [`SMC_WS_WIDTH-1:`SMC_WS_FINE_WIDTH] st_coarse;
   logic [`SMC_WS_FINE_WIDTH-1:0]             cnt_fine;
   logic [`SMC_WS_WIDTH-1:`SMC_WS_FINE_WIDTH] cnt_coarse;

   logic from_setup;     // Entering RW from LE or STORE
   logic store_window;   // Read strobe may run, judged on the stored wait states
   logic count_window;   // Same, judged on the running count
   logic n_rd_next;

   assign st_fine    = store.ws_store[`SMC_WS_FINE_WIDTH-1:0];
   assign st_coarse  = store.ws_store[`SMC_WS_WIDTH-1:`SMC_WS_FINE_WIDTH];
   assign cnt_fine   = ws_count[`SMC_WS_FINE_WIDTH-1:0];
   assign cnt_coarse = ws_count[`SMC_WS_WIDTH-1:`SMC_WS_FINE_WIDTH];

   assign from_setup = (cur_state == SMC_LE) | (cur_state == SMC_STORE);

   assign store_window = (store.oete_store <= st_fine) | (st_coarse != '0) |
                         (store.ws_store == '0);
   assign count_window = (store.oete_store < cnt_fine) | (cnt_coarse != '0) |
                         (ws_count == '0);

   //----------------------------------------
   // Read strobe
   //----------------------------------------
   always_comb
   begin
      n_rd_next = 1'b1;
      if (next_state == SMC_RW)
      begin
         if (access.valid_access)
            n_rd_next = access.n_read;   // Direction of the new access
         else if (from_setup)
            n_rd_next = store_window ? n_r_read : 1'b1;
         else
            n_rd_next = count_window ? n_r_read : 1'b1;
      end
   end

   always_ff @(posedge sys_clk or negedge n_sys_reset)
   begin
      if (!n_sys_reset)
      begin
         n_rd <= 1'b1;
      end
      else
      begin
         n_rd <= n_rd_next;
      end
   end

   // Strobe only follows an RW state
   rd_only_in_rw: assert property (
      @(posedge sys_clk) disable iff (!n_sys_reset)
      ($past(next_state) != SMC_RW) |-> n_rd
   )
   else
      $error("n_rd low without next_state SMC_RW");

endmodule

/* logic/smc_strobe_top.sv */
// SMC strobe generator top, connects cycle latch, write, full-cycle and read blocks
`timescale 1ns/1ps
`include "smc_config.svh"

module smc_strobe_top
   import smc_pkg::*;
(
   input  logic              sys_clk,
   input  logic              n_sys_reset,
   input  smc_state_e        cur_state,
   input  smc_state_e        next_state,
   input  smc_access_t       access,
   input  smc_timing_store_t store,
   input  smc_timing_count_t count,
   input  logic              smc_done,
   input  logic              mac_done,
   output smc_cycle_attr_t   cycle_attr,
   output logic              busy,
   output logic              full,
   output smc_ext_strobe_t   ext_strobe
);

   logic [`SMC_BE_WIDTH-1:0] n_we;
   logic                     n_wr;
   logic                     n_ext_oe;
   logic                     n_rd;

   //----------------------------------------
   // Blocks
   //----------------------------------------
   smc_cycle_latch smc_cycle_latch_inst (
      .sys_clk     (sys_clk),
      .n_sys_reset (n_sys_reset),
      .access      (access),
      .smc_done    (smc_done),
      .mac_done    (mac_done),
      .next_state  (next_state),
      .cycle_attr  (cycle_attr),
      .busy        (busy)
   );

   smc_write_strobe smc_write_strobe_inst (
      .sys_clk     (sys_clk),
      .n_sys_reset (n_sys_reset),
      .access      (access),
      .n_r_read    (cycle_attr.n_r_read),   // Latched direction
      .next_state  (next_state),
      .n_we        (n_we),
      .n_wr        (n_wr),
      .n_ext_oe    (n_ext_oe)
   );

   smc_full_cycle smc_full_cycle_inst (
      .sys_clk      (sys_clk),
      .n_sys_reset  (n_sys_reset),
      .cur_state    (cur_state),
      .next_state   (next_state),
      .valid_access (access.valid_access),
      .smc_done     (smc_done),
      .store        (store),
      .count        (count),
      .full         (full)
   );

   smc_read_strobe smc_read_strobe_inst (
      .sys_clk     (sys_clk),
      .n_sys_reset (n_sys_reset),
      .cur_state   (cur_state),
      .next_state  (next_state),
      .access      (access),
      .n_r_read    (cycle_attr.n_r_read),
      .store       (store),
      .ws_count    (count.ws_count),
      .n_rd        (n_rd)
   );

   // Bundle the external strobes
   assign ext_strobe = '{n_rd: n_rd, n_ext_oe: n_ext_oe, n_we: n_we, n_wr: n_wr};

endmodule

/* test/smc_strobe_checker.sv */
// SMC strobe checker, concurrent assertions recomputing every strobe generator output
`timescale 1ns/1ps
`include "smc_config.svh"

module smc_strobe_checker
   import smc_pkg::*;
(
   input  logic              sys_clk,
   input  logic              n_sys_reset,
   input  smc_state_e        cur_state,
   input  smc_state_e        next_state,
   input  smc_access_t       access,
   input  smc_timing_store_t store,
   input  smc_timing_count_t count,
   input  logic              smc_done,
   input  logic              mac_done,
   input  smc_cycle_attr_t   cycle_attr,
   input  logic              busy,
   input  logic              full,
   input  smc_ext_strobe_t   ext_strobe,
   output logic              error_seen
);

   localparam smc_ext_strobe_t STROBE_IDLE = '{n_rd: 1'b1, n_ext_oe: 1'b1, n_we: '1, n_wr: 1'b1};

   smc_cycle_attr_t               model_attr;   // Expected latched direction and chip select
   smc_ext_strobe_t               exp_strobe;   // Strobes expected one cycle later
   logic                          exp_full;
   logic                          wr_go;
   logic [`SMC_WS_FINE_WIDTH-1:0] ws_fine;
   logic [`SMC_WS_FINE_WIDTH-1:0] st_fine;
   logic                          ws_coarse;
   logic                          st_coarse;

   initial
      error_seen = 1'b0;

   task automatic flag_error(input string what);
      begin
         $display("ERROR at %0t: %s does not match the expected value", $time, what);
         error_seen = 1'b1;
      end
   endtask

   //----------------------------------------
   // Expected values from this cycle's inputs
   //----------------------------------------
   always_comb
   begin
      ws_fine   = count.ws_count[`SMC_WS_FINE_WIDTH-1:0];
      st_fine   = store.ws_store[`SMC_WS_FINE_WIDTH-1:0];
      ws_coarse = (count.ws_count >> `SMC_WS_FINE_WIDTH) != 0;
      st_coarse = (store.ws_store >> `SMC_WS_FINE_WIDTH) != 0;

      wr_go = (next_state != SMC_STORE) &&
              (access.valid_access ? access.n_read : model_attr.n_r_read);
      exp_strobe.n_wr     = !wr_go;
      exp_strobe.n_we     = wr_go ? access.n_be : '1;
      exp_strobe.n_ext_oe = !(wr_go && (access.valid_access || next_state != SMC_IDLE));

      exp_strobe.n_rd = 1'b1;
      exp_full        = 1'b0;
      if (next_state == SMC_RW)
      begin
         if (access.valid_access)
            exp_strobe.n_rd = access.n_read;
         else if (cur_state == SMC_LE || cur_state == SMC_STORE)
         begin
            if (store.oete_store <= st_fine || st_coarse || store.ws_store == 0)
               exp_strobe.n_rd = model_attr.n_r_read;
         end
         else if (store.oete_store < ws_fine || ws_coarse || count.ws_count == 0)
            exp_strobe.n_rd = model_attr.n_r_read;

         if (cur_state == SMC_LE)
            exp_full = (store.wete_store < ws_fine || ws_coarse) && count.wele_count < 2;
         else if (cur_state == SMC_STORE)
            exp_full = (store.wete_store < ws_fine || ws_coarse) && count.wele_count == 0;
         else if (cur_state == SMC_RW || cur_state == SMC_FLOAT)
         begin
            if (access.valid_access)
               exp_full = 1'b0;
            else if (smc_done)
               exp_full = (store.wete_store < st_fine || st_coarse) && store.wele_store == 0;
            else if (store.wete_store == 3)
               exp_full = count.ws_count > 4 && count.wele_count < 2;
            else
               exp_full = (store.wete_store + 1 < ws_fine || ws_coarse) &&
                          count.wele_count < 2;
         end
      end
   end

   // Reference for the burst latch
   always_ff @(posedge sys_clk or negedge n_sys_reset)
   begin
      if (!n_sys_reset)
         model_attr <= '0;
      else if (access.valid_access)
         model_attr <= '{n_r_read: access.n_read, r_cs: access.cs};
      else if (smc_done && mac_done)
         model_attr <= '0;   // Burst closed
   end

   //----------------------------------------
   // Checks
   //----------------------------------------
   reset_outputs: assert property (@(posedge sys_clk)
      (!n_sys_reset || $rose(n_sys_reset)) |->
         (cycle_attr == '0 && !busy && !full && ext_strobe == STROBE_IDLE))
      else flag_error("reset value");
   attr_follows: assert property (@(posedge sys_clk) cycle_attr == model_attr)
      else flag_error("cycle_attr");
   busy_follows: assert property (@(posedge sys_clk) disable iff (!n_sys_reset)
      $past(n_sys_reset) |-> busy == ($past(next_state) != SMC_IDLE))
      else flag_error("busy");
   full_follows: assert property (@(posedge sys_clk) disable iff (!n_sys_reset)
      $past(n_sys_reset) |-> full == $past(exp_full))
      else flag_error("full");
   write_follows: assert property (@(posedge sys_clk) disable iff (!n_sys_reset)
      $past(n_sys_reset) |-> {ext_strobe.n_we, ext_strobe.n_wr, ext_strobe.n_ext_oe} ==
         $past({exp_strobe.n_we, exp_strobe.n_wr, exp_strobe.n_ext_oe}))
      else flag_error("n_we/n_wr/n_ext_oe");
   read_follows: assert property (@(posedge sys_clk) disable iff (!n_sys_reset)
      $past(n_sys_reset) |-> ext_strobe.n_rd == $past(exp_strobe.n_rd))
      else flag_error("n_rd");
   wr_implies_we_off: assert property (@(posedge sys_clk)
      ext_strobe.n_wr |-> ext_strobe.n_we == '1)
      else flag_error("n_we with n_wr high");
   rd_needs_rw: assert property (@(posedge sys_clk) disable iff (!n_sys_reset)
      ($past(next_state) != SMC_RW) |-> ext_strobe.n_rd)
      else flag_error("n_rd outside RW");

endmodule

/* test/tb_smc_strobe.sv */
// SMC strobe generator testbench, clock, reset, directed and random controller stimulus
`timescale 1ns/1ps
`include "smc_config.svh"

module tb_smc_strobe
   import smc_pkg::*;
();

   localparam int          CYCLE_LIMIT = 600;   // About 430 cycles of stimulus plus margin
   localparam smc_access_t NO_ACC      = '0;
   localparam smc_access_t WR_ACC      = '{1'b1, 1'b1, 1'b1, 4'b1100};
   localparam smc_access_t RD_ACC      = '{1'b1, 1'b0, 1'b1, 4'b1111};

   logic              sys_clk;
   logic              n_sys_reset;
   smc_state_e        cur_state;
   smc_state_e        next_state;
   smc_access_t       access;
   smc_timing_store_t store;
   smc_timing_count_t count;
   logic              smc_done;
   logic              mac_done;
   smc_cycle_attr_t   cycle_attr;
   logic              busy;
   logic              full;
   smc_ext_strobe_t   ext_strobe;
   logic              error_seen;
   int                cycle_count = 0;
   integer            seed;
   logic [31:0]       rnd;

   smc_strobe_top smc_strobe_top_inst (.*);
   smc_strobe_checker smc_strobe_checker_inst (.*);

   initial
   begin
      sys_clk = 1'b0;
      forever
         #10 sys_clk = ~sys_clk;
   end

   // Run limit
   always @(posedge sys_clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT)
      begin
         $display("Timeout after %0d cycles, stimulus did not finish", cycle_count);
         $display("Done: errors found");
         $fatal(1, "run stopped by timeout");
      end
   end

   initial
   begin
      wait (error_seen === 1'b1);
      $display("Done: errors found");
      $fatal(1, "assertion check failed");
   end

   //----------------------------------------
   // Stimulus tasks
   //----------------------------------------
   task automatic step(input smc_state_e cur, input smc_state_e nxt,
                       input smc_access_t acc, input logic [1:0] done);
      begin
         @(posedge sys_clk);
         #2;
         cur_state  = cur;
         next_state = nxt;
         access     = acc;
         {smc_done, mac_done} = done;   // smc_done, mac_done
      end
   endtask

   // Applies to the cycle of the step just before it
   task automatic set_timing(input logic [`SMC_EDGE_WIDTH-1:0] wele_s,
                             input logic [`SMC_EDGE_WIDTH-1:0] wete_s,
                             input logic [`SMC_EDGE_WIDTH-1:0] oete_s,
                             input logic [`SMC_WS_WIDTH-1:0] ws_s,
                             input logic [`SMC_EDGE_WIDTH-1:0] wele_c,
                             input logic [`SMC_WS_WIDTH-1:0] ws_c);
      begin
         store = '{wele_s, wete_s, oete_s, ws_s};
         count = '{wele_c, ws_c};
      end
   endtask

   task automatic random_cycle();
      begin
         @(posedge sys_clk);
         #2;
         rnd        = $random(seed);
         cur_state  = smc_state_e'(5'b00001 << (rnd[2:0] % 5));   // Always one-hot
         next_state = smc_state_e'(5'b00001 << (rnd[5:3] % 5));
         access     = rnd[12:6];
         smc_done   = rnd[13];
         mac_done   = rnd[14];
         rnd        = $random(seed);
         store      = rnd[13:0];
         count      = rnd[23:14];
      end
   endtask

   //----------------------------------------
   // Main sequence
   //----------------------------------------
   initial
   begin
      seed        = 32'hdeca_b53c;
      n_sys_reset = 1'b1;
      cur_state   = SMC_IDLE;
      next_state  = SMC_IDLE;
      access      = NO_ACC;
      smc_done    = 1'b0;
      mac_done    = 1'b0;
      set_timing(0, 0, 0, 8'd0, 0, 8'd0);
      #1 n_sys_reset = 1'b0;   // Clean falling edge for the asynchronous reset
      repeat (4) @(posedge sys_clk);
      #2 n_sys_reset = 1'b1;

      // Write burst, IDLE to LE to RW and through STORE
      step(SMC_IDLE, SMC_IDLE, NO_ACC, 2'b00);
      step(SMC_IDLE, SMC_LE, WR_ACC, 2'b00);
      set_timing(0, 1, 1, 8'd6, 0, 8'd6);
      step(SMC_LE, SMC_RW, NO_ACC, 2'b00);
      step(SMC_RW, SMC_RW, NO_ACC, 2'b00);
      set_timing(0, 3, 1, 8'd6, 1, 8'd5);   // Late trailing edge, long wait
      step(SMC_RW, SMC_RW, NO_ACC, 2'b00);
      set_timing(0, 1, 1, 8'd6, 1, 8'd3);
      step(SMC_RW, SMC_STORE, NO_ACC, 2'b00);
      step(SMC_STORE, SMC_RW, NO_ACC, 2'b00);
      set_timing(0, 0, 1, 8'd6, 0, 8'd2);
      step(SMC_STORE, SMC_RW, NO_ACC, 2'b00);
      set_timing(0, 0, 1, 8'd6, 1, 8'd6);   // Edge count too high from STORE
      step(SMC_RW, SMC_RW, NO_ACC, 2'b10);
      set_timing(0, 0, 1, 8'd2, 0, 8'd1);   // smc_done alone, store fields decide
      step(SMC_RW, SMC_IDLE, NO_ACC, 2'b11);
      step(SMC_IDLE, SMC_IDLE, NO_ACC, 2'b00);

      // Read burst, output-enable edge late then in window
      step(SMC_IDLE, SMC_LE, RD_ACC, 2'b00);
      set_timing(0, 0, 3, 8'd2, 0, 8'd2);
      step(SMC_LE, SMC_RW, NO_ACC, 2'b00);
      step(SMC_LE, SMC_RW, NO_ACC, 2'b00);
      set_timing(0, 0, 2, 8'd2, 0, 8'd2);
      step(SMC_RW, SMC_FLOAT, NO_ACC, 2'b00);
      step(SMC_FLOAT, SMC_RW, NO_ACC, 2'b00);
      set_timing(0, 0, 1, 8'd6, 0, 8'd3);
      step(SMC_RW, SMC_RW, NO_ACC, 2'b00);
      set_timing(0, 0, 3, 8'd6, 0, 8'd0);   // Count expired
      step(SMC_RW, SMC_RW, RD_ACC, 2'b00);
      step(SMC_RW, SMC_IDLE, NO_ACC, 2'b11);
      step(SMC_IDLE, SMC_IDLE, NO_ACC, 2'b00);

      repeat (400)
         random_cycle();
      repeat (2) @(posedge sys_clk);
      @(negedge sys_clk);   // Checks of the last edge have run by now

      if (error_seen)
      begin
         $display("Done: errors found");
         $fatal(1, "checks failed");
      end
      else
      begin
         $display("Done: no errors");
         $finish;
      end
   end

endmodule

/* smc_strobe.f */
+incdir+logic
logic/smc_pkg.sv
logic/smc_cycle_latch.sv
logic/smc_write_strobe.sv
logic/smc_full_cycle.sv
logic/smc_read_strobe.sv
logic/smc_strobe_top.sv
test/smc_strobe_checker.sv
test/tb_smc_strobe.sv
